//--- include/switch_settings.svh
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

// input ports, output ports and banks all share this count
`define NUM_PORTS 4

// one page holds a whole packet
`define PAGE_WORDS 8
`define PAGES_PER_BANK 8

// every page of every bank can sit in one queue, no overflow possible
`define QUEUE_DEPTH (`NUM_PORTS * `PAGES_PER_BANK)

// almost_full once free pages drop to this level
`define ALMOST_FULL_PAGES 2

`define WORD_BITS 16

`endif

//--- hdl/switch_pkg.sv
`include "switch_settings.svh"

package switch_pkg;

    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;
    typedef logic [$clog2(`PAGES_PER_BANK)-1:0] page_id_t;
    typedef logic [$clog2(`PAGE_WORDS)-1:0] word_idx_t;
    // one wider than the index, holds 1..8
    typedef logic [$clog2(`PAGE_WORDS):0] word_cnt_t;

    typedef enum logic {
        PRIO_LOW  = 1'b0,
        PRIO_HIGH = 1'b1
    } prio_e;

    // header word layout: prio in bit 4, dest in bits 1:0
    typedef struct packed {
        logic [`WORD_BITS-6:0] rsvd_hi;
        prio_e                 prio;
        logic [1:0]            rsvd_lo;
        port_id_t              dest;
    } header_t;

    // router to bank, sop carries no data
    typedef struct packed {
        logic     vld;
        logic     sop;
        logic     eop;
        port_id_t dest;
        prio_e    prio;
        word_t    data;
    } wr_beat_t;

    // one finished packet sitting in a bank
    typedef struct packed {
        logic      vld;
        port_id_t  bank;
        page_id_t  page;
        word_cnt_t count;
        port_id_t  dest;
        prio_e     prio;
    } descriptor_t;

    // last also releases the page
    typedef struct packed {
        logic      en;
        page_id_t  page;
        word_idx_t word_idx;
        logic      last;
    } rd_req_t;

    typedef enum logic {
        EG_IDLE   = 1'b0,
        EG_STREAM = 1'b1
    } egress_state_e;

endpackage

//--- hdl/ingress_router.sv
`include "switch_settings.svh"

module ingress_router (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`NUM_PORTS-1:0]                  wr_sop,
    input  logic [`NUM_PORTS-1:0]                  wr_eop,
    input  logic [`NUM_PORTS-1:0]                  wr_vld,
    input  switch_pkg::word_t [`NUM_PORTS-1:0]     wr_data,
    input  logic [`NUM_PORTS-1:0]                  bank_full,
    output switch_pkg::wr_beat_t [`NUM_PORTS-1:0]  beat
);

    // header view of the incoming word
    switch_pkg::header_t [`NUM_PORTS-1:0] hdr;

    // packet in progress was accepted at its header
    logic [`NUM_PORTS-1:0] accept;

    // dest and prio held for the data beats
    switch_pkg::port_id_t hold_dest [`NUM_PORTS];
    switch_pkg::prio_e    hold_prio [`NUM_PORTS];

    // data beat = vld without sop
    logic [`NUM_PORTS-1:0] data_beat;

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            hdr[p] = switch_pkg::header_t'(wr_data[p]);
            data_beat[p] = wr_vld[p] && !wr_sop[p];
        end
    end

    // accept/drop decided only at the header
    always_ff @(posedge clk) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (!rst_n) begin
                accept[p] <= 1'b0;
            end else if (wr_sop[p]) begin
                accept[p] <= !bank_full[p];
            end else if (data_beat[p] && wr_eop[p]) begin
                // stray beats after eop are ignored
                accept[p] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (wr_sop[p]) begin
                hold_dest[p] <= hdr[p].dest;
                hold_prio[p] <= hdr[p].prio;
            end
        end
    end

    // one register stage toward bank p
    always_ff @(posedge clk) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            beat[p].data <= wr_data[p];
            // on the header beat take the fields straight from the word
            beat[p].dest <= wr_sop[p] ? hdr[p].dest : hold_dest[p];
            beat[p].prio <= wr_sop[p] ? hdr[p].prio : hold_prio[p];
            if (!rst_n) begin
                beat[p].vld <= 1'b0;
                beat[p].sop <= 1'b0;
                beat[p].eop <= 1'b0;
            end else begin
                beat[p].sop <= wr_sop[p] && !bank_full[p];
                beat[p].vld <= data_beat[p] && accept[p];
                beat[p].eop <= data_beat[p] && accept[p] && wr_eop[p];
            end
        end
    end

endmodule

//--- hdl/page_bank.sv
`include "switch_settings.svh"

module page_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  switch_pkg::wr_beat_t    beat,
    output switch_pkg::descriptor_t desc,
    input  switch_pkg::rd_req_t     rd_req,
    output switch_pkg::word_t       rd_word,
    output logic                    full,
    output logic                    almost_full
);

    // packet memory, one page per packet
    switch_pkg::word_t mem [`PAGES_PER_BANK][`PAGE_WORDS];

    // 1 = page free
    logic [`PAGES_PER_BANK-1:0] free_map;
    logic [$clog2(`PAGES_PER_BANK):0] free_cnt;
    switch_pkg::page_id_t alloc_page;

    // page and word count of the packet being written
    switch_pkg::page_id_t  wr_page;
    switch_pkg::word_cnt_t wr_cnt;

    // lowest free page, plus number of free pages
    always_comb begin
        alloc_page = '0;
        free_cnt = '0;
        for (int i = `PAGES_PER_BANK - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_page = switch_pkg::page_id_t'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign full = (free_cnt == '0);
    assign almost_full = (free_cnt <= `ALMOST_FULL_PAGES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
            wr_cnt <= '0;
            desc.vld <= 1'b0;
        end else begin
            desc.vld <= 1'b0;
            // router never sends sop to a full bank, guard anyway
            if (beat.sop && !full) begin
                free_map[alloc_page] <= 1'b0;
                wr_cnt <= '0;
            end else if (beat.vld) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (beat.eop) begin
                    desc.vld <= 1'b1;
                end
            end
            // allocated and released pages never collide
            if (rd_req.en && rd_req.last) begin
                free_map[rd_req.page] <= 1'b1;
            end
        end
    end

    // descriptor fields, qualified by desc.vld
    always_ff @(posedge clk) begin
        if (beat.sop && !full) begin
            wr_page <= alloc_page;
        end
        if (beat.vld && beat.eop) begin
            desc.bank <= switch_pkg::port_id_t'(BANK_ID);
            desc.page <= wr_page;
            desc.count <= wr_cnt + 1'b1;
            desc.dest <= beat.dest;
            desc.prio <= beat.prio;
        end
    end

    // write port and registered read port
    always_ff @(posedge clk) begin
        if (beat.vld) begin
            mem[wr_page][switch_pkg::word_idx_t'(wr_cnt)] <= beat.data;
        end
        if (rd_req.en) begin
            rd_word <= mem[rd_req.page][rd_req.word_idx];
        end
    end

endmodule

//--- hdl/egress_scheduler.sv
`include "switch_settings.svh"

module egress_scheduler (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  switch_pkg::descriptor_t [`NUM_PORTS-1:0]  desc,
    input  switch_pkg::word_t [`NUM_PORTS-1:0]        rd_word,
    output switch_pkg::rd_req_t [`NUM_PORTS-1:0]      rd_req,
    input  logic [`NUM_PORTS-1:0]                     ready,
    output logic [`NUM_PORTS-1:0]                     rd_sop,
    output logic [`NUM_PORTS-1:0]                     rd_eop,
    output logic [`NUM_PORTS-1:0]                     rd_vld,
    output switch_pkg::word_t [`NUM_PORTS-1:0]        rd_data
);

    // one queue per (dest, prio)
    localparam int QUEUES = `NUM_PORTS * 2;
    localparam int QW = $clog2(QUEUES);
    localparam int PW = $clog2(`QUEUE_DEPTH);

    typedef logic [QW-1:0] qidx_t;
    typedef logic [PW-1:0] ptr_t;
    typedef logic [PW:0] qcnt_t;
    typedef logic [$clog2(`NUM_PORTS + 1)-1:0] npush_t;

    switch_pkg::descriptor_t q_mem [QUEUES][`QUEUE_DEPTH];
    ptr_t [QUEUES-1:0] q_head;
    ptr_t [QUEUES-1:0] q_tail;
    qcnt_t [QUEUES-1:0] q_cnt;
    switch_pkg::descriptor_t head_desc [QUEUES];

    // push side
    qidx_t push_q [`NUM_PORTS];
    ptr_t push_slot [`NUM_PORTS];
    npush_t [QUEUES-1:0] push_n;
    logic [QUEUES-1:0] pop_q;

    // per output
    switch_pkg::egress_state_e state [`NUM_PORTS];
    switch_pkg::descriptor_t cur [`NUM_PORTS];
    switch_pkg::word_cnt_t rd_idx [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] last_beat;
    logic [`NUM_PORTS-1:0] pick;
    qidx_t pick_q [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] bank_busy;

    // request issued last cycle, data arrives now
    logic [`NUM_PORTS-1:0] pend_vld;
    logic [`NUM_PORTS-1:0] pend_sop;
    logic [`NUM_PORTS-1:0] pend_eop;
    switch_pkg::port_id_t [`NUM_PORTS-1:0] pend_bank;

    // slots in ascending bank order when several hit one queue
    always_comb begin
        push_n = '0;
        for (int b = 0; b < `NUM_PORTS; b++) begin
            push_q[b] = {desc[b].dest, desc[b].prio};
            push_slot[b] = q_tail[push_q[b]] + ptr_t'(push_n[push_q[b]]);
            if (desc[b].vld) begin
                push_n[push_q[b]] = push_n[push_q[b]] + 1'b1;
            end
        end
        for (int q = 0; q < QUEUES; q++) begin
            head_desc[q] = q_mem[q][q_head[q]];
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `NUM_PORTS; b++) begin
            if (desc[b].vld) begin
                q_mem[push_q[b]][push_slot[b]] <= desc[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_head <= '0;
            q_tail <= '0;
            q_cnt <= '0;
        end else begin
            for (int q = 0; q < QUEUES; q++) begin
                q_tail[q] <= q_tail[q] + ptr_t'(push_n[q]);
                q_head[q] <= q_head[q] + ptr_t'(pop_q[q]);
                q_cnt[q] <= q_cnt[q] + qcnt_t'(push_n[q]) - qcnt_t'(pop_q[q]);
            end
        end
    end

    // banks already streaming to some output
    always_comb begin
        bank_busy = '0;
        rd_req = '0;
        for (int o = 0; o < `NUM_PORTS; o++) begin
            last_beat[o] = (rd_idx[o] == cur[o].count - 1'b1);
            if (state[o] == switch_pkg::EG_STREAM) begin
                bank_busy[cur[o].bank] = 1'b1;
                rd_req[cur[o].bank].en = 1'b1;
                rd_req[cur[o].bank].page = cur[o].page;
                rd_req[cur[o].bank].word_idx = switch_pkg::word_idx_t'(rd_idx[o]);
                rd_req[cur[o].bank].last = last_beat[o];
            end
        end
    end

    // strict priority pick, lower output wins a shared bank
    always_comb begin
        logic [`NUM_PORTS-1:0] claimed;
        qidx_t qh;
        qidx_t ql;
        qidx_t qsel;
        logic have;
        claimed = '0;
        pick = '0;
        pop_q = '0;
        for (int o = 0; o < `NUM_PORTS; o++) begin
            qh = {switch_pkg::port_id_t'(o), switch_pkg::PRIO_HIGH};
            ql = {switch_pkg::port_id_t'(o), switch_pkg::PRIO_LOW};
            have = (q_cnt[qh] != '0) || (q_cnt[ql] != '0);
            qsel = (q_cnt[qh] != '0) ? qh : ql;
            pick_q[o] = qsel;
            if (state[o] == switch_pkg::EG_IDLE && ready[o] && have &&
                !bank_busy[head_desc[qsel].bank] && !claimed[head_desc[qsel].bank]) begin
                pick[o] = 1'b1;
                pop_q[qsel] = 1'b1;
                claimed[head_desc[qsel].bank] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            if (!rst_n) begin
                state[o] <= switch_pkg::EG_IDLE;
                rd_idx[o] <= '0;
                pend_vld[o] <= 1'b0;
                pend_sop[o] <= 1'b0;
                pend_eop[o] <= 1'b0;
                rd_vld[o] <= 1'b0;
                rd_sop[o] <= 1'b0;
                rd_eop[o] <= 1'b0;
            end else begin
                rd_vld[o] <= pend_vld[o];
                rd_sop[o] <= pend_sop[o];
                rd_eop[o] <= pend_eop[o];
                pend_vld[o] <= (state[o] == switch_pkg::EG_STREAM);
                pend_sop[o] <= (state[o] == switch_pkg::EG_STREAM) && (rd_idx[o] == '0);
                pend_eop[o] <= (state[o] == switch_pkg::EG_STREAM) && last_beat[o];
                case (state[o])
                    switch_pkg::EG_IDLE: begin
                        if (pick[o]) begin
                            state[o] <= switch_pkg::EG_STREAM;
                            rd_idx[o] <= '0;
                        end
                    end
                    switch_pkg::EG_STREAM: begin
                        // one read per cycle until the last word
                        rd_idx[o] <= rd_idx[o] + 1'b1;
                        if (last_beat[o]) begin
                            state[o] <= switch_pkg::EG_IDLE;
                        end
                    end
                    default: state[o] <= switch_pkg::EG_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < `NUM_PORTS; o++) begin
            if (pick[o]) begin
                cur[o] <= head_desc[pick_q[o]];
            end
            pend_bank[o] <= cur[o].bank;
            rd_data[o] <= rd_word[pend_bank[o]];
        end
    end

endmodule

//--- hdl/shared_buffer_switch.sv
`include "switch_settings.svh"

module shared_buffer_switch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`NUM_PORTS-1:0]              wr_sop,
    input  logic [`NUM_PORTS-1:0]              wr_eop,
    input  logic [`NUM_PORTS-1:0]              wr_vld,
    input  switch_pkg::word_t [`NUM_PORTS-1:0] wr_data,
    output logic [`NUM_PORTS-1:0]              full,
    output logic [`NUM_PORTS-1:0]              almost_full,
    input  logic [`NUM_PORTS-1:0]              ready,
    output logic [`NUM_PORTS-1:0]              rd_sop,
    output logic [`NUM_PORTS-1:0]              rd_eop,
    output logic [`NUM_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [`NUM_PORTS-1:0] rd_data
);

    // router to banks
    switch_pkg::wr_beat_t [`NUM_PORTS-1:0] bank_beat;

    // banks to scheduler and back
    switch_pkg::descriptor_t [`NUM_PORTS-1:0] bank_desc;
    switch_pkg::rd_req_t [`NUM_PORTS-1:0] bank_rd_req;
    switch_pkg::word_t [`NUM_PORTS-1:0] bank_rd_word;

    ingress_router ingress_router_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_sop    (wr_sop),
        .wr_eop    (wr_eop),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .bank_full (full),
        .beat      (bank_beat)
    );

    // input i always lands in bank i
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_bank
        page_bank #(
            .BANK_ID (i)
        ) page_bank_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .beat        (bank_beat[i]),
            .desc        (bank_desc[i]),
            .rd_req      (bank_rd_req[i]),
            .rd_word     (bank_rd_word[i]),
            .full        (full[i]),
            .almost_full (almost_full[i])
        );
    end

    egress_scheduler egress_scheduler_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .desc    (bank_desc),
        .rd_word (bank_rd_word),
        .rd_req  (bank_rd_req),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

endmodule

//--- test/switch_assert.sv
`include "switch_settings.svh"

module switch_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`NUM_PORTS-1:0] rd_sop,
    input logic [`NUM_PORTS-1:0] rd_eop,
    input logic [`NUM_PORTS-1:0] rd_vld,
    input logic [`NUM_PORTS-1:0] full,
    input logic [`NUM_PORTS-1:0] almost_full
);

    // read back by the testbench at the end
    int failures = 0;

    // outputs held low through reset
    a_reset_low: assert property (@(posedge clk)
        !rst_n |=> (rd_sop == '0 && rd_eop == '0 && rd_vld == '0 && full == '0 &&
                    almost_full == '0))
        else begin
            failures++;
            $error("outputs not low during reset");
        end

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        a_sop_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_sop[p] |-> rd_vld[p])
            else begin
                failures++;
                $error("rd_sop without rd_vld on output %0d", p);
            end
        a_eop_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_eop[p] |-> rd_vld[p])
            else begin
                failures++;
                $error("rd_eop without rd_vld on output %0d", p);
            end
        // no hole between sop and eop
        a_no_gap: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_vld[p] && !rd_eop[p]) |=> rd_vld[p])
            else begin
                failures++;
                $error("rd_vld dropped inside a packet on output %0d", p);
            end
    end

endmodule

bind shared_buffer_switch switch_assert switch_assert_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_sop      (rd_sop),
    .rd_eop      (rd_eop),
    .rd_vld      (rd_vld),
    .full        (full),
    .almost_full (almost_full)
);

//--- test/switch_tb.sv
`include "switch_settings.svh"

module switch_tb;

    // one sent packet as the checker expects it
    typedef struct packed {
        switch_pkg::port_id_t  src;
        switch_pkg::port_id_t  dest;
        switch_pkg::prio_e     prio;
        switch_pkg::word_cnt_t len;
        logic [7:0]            seq;
    } exp_pkt_t;

    typedef logic [`NUM_PORTS-1:0] port_mask_t;

    logic clk;
    logic rst_n;
    port_mask_t wr_sop;
    port_mask_t wr_eop;
    port_mask_t wr_vld;
    switch_pkg::word_t [`NUM_PORTS-1:0] wr_data;
    port_mask_t full;
    port_mask_t almost_full;
    port_mask_t ready;
    port_mask_t rd_sop;
    port_mask_t rd_eop;
    port_mask_t rd_vld;
    switch_pkg::word_t [`NUM_PORTS-1:0] rd_data;

    integer seed = 68612;
    int err_count = 0;
    int checks_done = 0;
    int tests_done = 0;
    int rx_total = 0;
    int words_sent = 0;
    int cycle_cnt = 0;

    // packets in flight, oldest first
    exp_pkt_t exp_list [$];
    switch_pkg::prio_e arrival_prio [$];
    logic [7:0] seq_next [`NUM_PORTS] = '{default: 8'd0};
    int sent_cnt [`NUM_PORTS] = '{default: 0};
    int rx_cnt [`NUM_PORTS] = '{default: 0};

    // packet being rebuilt on each output
    port_mask_t in_pkt = '0;
    switch_pkg::port_id_t cur_src [`NUM_PORTS];
    logic [7:0] cur_seq [`NUM_PORTS];
    switch_pkg::word_cnt_t cur_idx [`NUM_PORTS];

    shared_buffer_switch shared_buffer_switch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .full        (full),
        .almost_full (almost_full),
        .ready       (ready),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    always #50 clk = ~clk;

    // src and seq up top, so a word names its own packet
    function automatic switch_pkg::word_t expected_word(input switch_pkg::port_id_t src,
            input logic [7:0] seq, input switch_pkg::word_idx_t idx);
        logic [2:0] tag;
        tag = 3'(src) + seq[2:0] + idx;
        return {src, seq, idx, tag ^ 3'b101};
    endfunction

    function automatic port_mask_t port_bit(input int p, input logic on);
        port_bit = '0;
        port_bit[p] = on;
    endfunction

    task automatic check_word(input switch_pkg::word_t got, input switch_pkg::word_t exp,
            input string what);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input switch_pkg::word_cnt_t got,
            input switch_pkg::word_cnt_t exp, input string what);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_port(input switch_pkg::port_id_t got, input switch_pkg::port_id_t exp,
            input string what);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_prio(input switch_pkg::prio_e got, input switch_pkg::prio_e exp,
            input string what);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_level(input port_mask_t got, input port_mask_t exp, input string what);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // header beat, keep=0 for a packet the bank must drop
    task automatic start_packet(input switch_pkg::port_id_t src, input switch_pkg::port_id_t dest,
            input switch_pkg::prio_e prio, input switch_pkg::word_cnt_t len, input logic keep,
            output exp_pkt_t pk);
        switch_pkg::header_t hdr;
        hdr = '0;
        hdr.dest = dest;
        hdr.prio = prio;
        // junk in the unused bits
        hdr.rsvd_hi = {3'b101, seq_next[src]};
        hdr.rsvd_lo = 2'b11;
        pk = '{src: src, dest: dest, prio: prio, len: len, seq: seq_next[src]};
        seq_next[src]++;
        words_sent += len;
        if (keep) begin
            exp_list.push_back(pk);
            sent_cnt[src]++;
        end
        wr_sop[src] <= 1'b1;
        wr_vld[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
        wr_data[src] <= switch_pkg::word_t'(hdr);
    endtask

    task automatic drive_data(input exp_pkt_t pk, input int i);
        wr_sop[pk.src] <= 1'b0;
        wr_vld[pk.src] <= 1'b1;
        wr_eop[pk.src] <= (i == pk.len - 1);
        wr_data[pk.src] <= expected_word(pk.src, pk.seq, switch_pkg::word_idx_t'(i));
    endtask

    // back-to-back beats on one input
    task automatic send_packet(input switch_pkg::port_id_t src, input switch_pkg::port_id_t dest,
            input switch_pkg::prio_e prio, input switch_pkg::word_cnt_t len, input logic keep);
        exp_pkt_t pk;
        @(posedge clk);
        start_packet(src, dest, prio, len, keep, pk);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            drive_data(pk, i);
        end
        @(posedge clk);
        wr_vld[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
    endtask

    // all inputs at once, pages per bank kept under the drop point
    task automatic random_traffic(input int pkts_per_port);
        int left [`NUM_PORTS];
        int idx [`NUM_PORTS];
        exp_pkt_t pk [`NUM_PORTS];
        port_mask_t busy;
        logic more;
        busy = '0;
        more = 1'b1;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            left[p] = pkts_per_port;
        end
        while (more) begin
            @(posedge clk);
            ready <= port_mask_t'($random(seed));
            more = 1'b0;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                wr_sop[p] <= 1'b0;
                wr_vld[p] <= 1'b0;
                wr_eop[p] <= 1'b0;
                if (busy[p]) begin
                    // gap now and then
                    if (($random(seed) & 3) != 0) begin
                        drive_data(pk[p], idx[p]);
                        idx[p]++;
                        busy[p] = (idx[p] < pk[p].len);
                    end
                end else if (left[p] > 0 && (sent_cnt[p] - rx_cnt[p]) < `PAGES_PER_BANK &&
                             ($random(seed) & 1) != 0) begin
                    start_packet(switch_pkg::port_id_t'(p), switch_pkg::port_id_t'($random(seed)),
                                 switch_pkg::prio_e'($random(seed) & 1),
                                 switch_pkg::word_cnt_t'(1 + ($random(seed) & 7)), 1'b1, pk[p]);
                    busy[p] = 1'b1;
                    idx[p] = 0;
                    left[p]--;
                end
                more = more || busy[p] || (left[p] > 0);
            end
        end
        @(posedge clk);
        wr_vld <= '0;
        wr_eop <= '0;
        ready <= '1;
    endtask

    task automatic wait_drained();
        while (exp_list.size() != 0 || in_pkt != '0) begin
            @(posedge clk);
        end
        // room for a stray duplicate to show up
        repeat (10) @(posedge clk);
    endtask

    // match by src and seq, then dest, length and order
    task automatic finish_packet(input switch_pkg::port_id_t o, input switch_pkg::word_cnt_t cnt);
        int hit;
        hit = -1;
        for (int i = 0; i < exp_list.size(); i++) begin
            if (hit < 0 && exp_list[i].src == cur_src[o] && exp_list[i].seq == cur_seq[o]) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            err_count++;
            $display("output %0d delivered a packet that was never sent or was dropped", o);
        end else begin
            for (int i = 0; i < hit; i++) begin
                if (exp_list[i].src == cur_src[o] && exp_list[i].dest == exp_list[hit].dest &&
                    exp_list[i].prio == exp_list[hit].prio) begin
                    err_count++;
                    $display("ERR %0t: output %0d passed seq %0d of input %0d before seq %0d",
                             $time, o, cur_seq[o], cur_src[o], exp_list[i].seq);
                end
            end
            check_port(o, exp_list[hit].dest, "output port");
            check_count(cnt, exp_list[hit].len, "packet length");
            arrival_prio.push_back(exp_list[hit].prio);
            rx_cnt[cur_src[o]]++;
            rx_total++;
            exp_list.delete(hit);
        end
        in_pkt[o] = 1'b0;
    endtask

    always @(posedge clk) begin : compare_outputs
        switch_pkg::word_t w;
        for (int o = 0; o < `NUM_PORTS; o++) begin
            w = rd_data[o];
            if (rst_n && rd_vld[o]) begin
                if (rd_sop[o]) begin
                    if (in_pkt[o]) begin
                        err_count++;
                        $display("output %0d started a packet before the last one ended", o);
                    end
                    in_pkt[o] = 1'b1;
                    cur_src[o] = w[15:14];
                    cur_seq[o] = w[13:6];
                    cur_idx[o] = '0;
                end
                if (!in_pkt[o]) begin
                    err_count++;
                    $display("output %0d sent a word outside any packet", o);
                end else begin
                    check_word(w, expected_word(cur_src[o], cur_seq[o],
                               switch_pkg::word_idx_t'(cur_idx[o])), "data word");
                    if (rd_eop[o]) begin
                        finish_packet(switch_pkg::port_id_t'(o), cur_idx[o] + 1'b1);
                    end
                    cur_idx[o] = cur_idx[o] + 1'b1;
                end
            end else if (rst_n && in_pkt[o]) begin
                err_count++;
                $display("output %0d paused in the middle of a packet", o);
                in_pkt[o] = 1'b0;
            end
        end
    end

    // limit grows with the words sent so far
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 20 * words_sent + 200) begin
            $display("timeout after %0d cycles with %0d packets never delivered",
                     cycle_cnt, exp_list.size());
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_test(input string name, input int errs_before);
        tests_done++;
        $display("test %0d %s finished with %0d errors", tests_done, name,
                 err_count - errs_before);
    endtask

    initial begin
        int errs;
        clk = 1'b0;
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        ready = '1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_count;
        @(negedge clk);
        check_level(rd_sop, '0, "rd_sop after reset");
        check_level(rd_eop, '0, "rd_eop after reset");
        check_level(rd_vld, '0, "rd_vld after reset");
        check_level(full, '0, "full after reset");
        check_level(almost_full, '0, "almost_full after reset");
        report_test("reset state", errs);

        errs = err_count;
        send_packet(2, 1, switch_pkg::PRIO_LOW, 5, 1'b1);
        wait_drained();
        report_test("single packet", errs);

        // both packets queued before output 0 opens
        errs = err_count;
        arrival_prio.delete();
        @(posedge clk);
        ready[0] <= 1'b0;
        send_packet(1, 0, switch_pkg::PRIO_LOW, 3, 1'b1);
        send_packet(1, 0, switch_pkg::PRIO_HIGH, 4, 1'b1);
        repeat (5) @(posedge clk);
        ready[0] <= 1'b1;
        wait_drained();
        check_prio(arrival_prio[0], switch_pkg::PRIO_HIGH, "first packet on output 0");
        check_prio(arrival_prio[1], switch_pkg::PRIO_LOW, "second packet on output 0");
        report_test("strict priority", errs);

        // bank 3 fills, the last two headers see full
        errs = err_count;
        @(posedge clk);
        ready <= '0;
        for (int k = 0; k < `PAGES_PER_BANK + 2; k++) begin
            send_packet(3, 2, switch_pkg::PRIO_LOW, switch_pkg::word_cnt_t'(1 + k % `PAGE_WORDS),
                        k < `PAGES_PER_BANK);
            @(negedge clk);
            check_level(almost_full,
                        port_bit(3, k + 1 >= `PAGES_PER_BANK - `ALMOST_FULL_PAGES), "almost_full");
            check_level(full, port_bit(3, k + 1 >= `PAGES_PER_BANK), "full");
        end
        @(posedge clk);
        ready <= '1;
        wait_drained();
        report_test("full and drop", errs);

        errs = err_count;
        random_traffic(12);
        wait_drained();
        report_test("random traffic", errs);

        if (shared_buffer_switch_inst.switch_assert_inst.failures != 0) begin
            $display("%0d framing assertions failed",
                     shared_buffer_switch_inst.switch_assert_inst.failures);
            err_count += shared_buffer_switch_inst.switch_assert_inst.failures;
        end
        $display("%0d tests, %0d checks, %0d packets received, %0d errors",
                 tests_done, checks_done, rx_total, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hdl/switch_pkg.sv
hdl/ingress_router.sv
hdl/page_bank.sv
hdl/egress_scheduler.sv
hdl/shared_buffer_switch.sv
test/switch_assert.sv
test/switch_tb.sv

//--- Bender.yml
package:
  name: shared_buffer_switch

sources:
  - include_dirs:
      - include
    files:
      - hdl/switch_pkg.sv
      - hdl/ingress_router.sv
      - hdl/page_bank.sv
      - hdl/egress_scheduler.sv
      - hdl/shared_buffer_switch.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/switch_assert.sv
      - test/switch_tb.sv
